/* design/rv_pkg.sv */
package rv_pkg;

    // ----------------------------------------------------------
    // basic widths
    // ----------------------------------------------------------
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes of the RV32I base set that the core recognizes
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

    // funct7 values separating ADD/SUB and the logical/arithmetic shifts
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // ----------------------------------------------------------
    // instruction kinds and control states
    // ----------------------------------------------------------
    typedef enum logic [5:0] {
        UNKNOWN,
        ADD, SUB, XOR, OR, AND,
        SLL, SRL, SRA, SLT, SLTU,
        ADDI, XORI, ORI, ANDI,
        SLLI, SRLI, SRAI, SLTI, SLTIU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR, LUI, AUIPC,
        FENCE, FENCEI, ECALL, EBREAK
    } inst_kind_e;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        HALT
    } core_state_e;

    // ----------------------------------------------------------
    // bundles passed between the blocks
    // ----------------------------------------------------------
    typedef struct packed {
        inst_kind_e kind;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        xlen_t      imm;
    } decoded_t;

    typedef struct packed {
        xlen_t result;
        xlen_t target;
        logic  redirect;
        logic  write_reg;
    } exec_result_t;

    typedef struct packed {
        xlen_t    pc;
        xlen_t    next_pc;
        xlen_t    data;
        reg_idx_t rd;
        logic     write;
    } retire_t;

endpackage

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  logic             i_clk,
    input  logic             reset_i,
    input  logic             load_i,
    input  rv_pkg::xlen_t    inst_i,
    output rv_pkg::decoded_t dec_o
);

    rv_pkg::xlen_t      inst_q;
    rv_pkg::opcode_t    opcode;
    logic [2:0]         funct3;
    rv_pkg::funct7_t    funct7;
    rv_pkg::inst_kind_e kind;
    rv_pkg::xlen_t      imm_i_type;
    rv_pkg::xlen_t      imm_b_type;
    rv_pkg::xlen_t      imm_u_type;
    rv_pkg::xlen_t      imm_j_type;
    rv_pkg::xlen_t      imm_shamt;

    // a cleared register decodes as UNKNOWN since opcode zero is not used
    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            inst_q <= '0;
        end else if (load_i) begin
            inst_q <= inst_i;
        end
    end

    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];
    assign funct7 = inst_q[31:25];

    // ----------------------------------------------------------
    // immediate formats
    // ----------------------------------------------------------
    assign imm_i_type = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_b_type = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                         inst_q[11:8], 1'b0};
    assign imm_u_type = {inst_q[31:12], 12'b0};
    assign imm_j_type = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                         inst_q[30:21], 1'b0};
    assign imm_shamt  = {27'b0, inst_q[24:20]};

    // ----------------------------------------------------------
    // opcode classification
    // ----------------------------------------------------------
    always_comb begin
        kind = rv_pkg::UNKNOWN;
        case (opcode)
            rv_pkg::OPC_OP: begin
                if (funct7 == rv_pkg::F7_BASE) begin
                    case (funct3)
                        3'b000: kind = rv_pkg::ADD;
                        3'b001: kind = rv_pkg::SLL;
                        3'b010: kind = rv_pkg::SLT;
                        3'b011: kind = rv_pkg::SLTU;
                        3'b100: kind = rv_pkg::XOR;
                        3'b101: kind = rv_pkg::SRL;
                        3'b110: kind = rv_pkg::OR;
                        default: kind = rv_pkg::AND;
                    endcase
                end else if (funct7 == rv_pkg::F7_ALT && funct3 == 3'b000) begin
                    kind = rv_pkg::SUB;
                end else if (funct7 == rv_pkg::F7_ALT && funct3 == 3'b101) begin
                    kind = rv_pkg::SRA;
                end
            end
            rv_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: kind = rv_pkg::ADDI;
                    3'b010: kind = rv_pkg::SLTI;
                    3'b011: kind = rv_pkg::SLTIU;
                    3'b100: kind = rv_pkg::XORI;
                    3'b110: kind = rv_pkg::ORI;
                    3'b111: kind = rv_pkg::ANDI;
                    3'b001: begin
                        if (funct7 == rv_pkg::F7_BASE) kind = rv_pkg::SLLI;
                    end
                    default: begin
                        if (funct7 == rv_pkg::F7_BASE) kind = rv_pkg::SRLI;
                        else if (funct7 == rv_pkg::F7_ALT) kind = rv_pkg::SRAI;
                    end
                endcase
            end
            rv_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000: kind = rv_pkg::BEQ;
                    3'b001: kind = rv_pkg::BNE;
                    3'b100: kind = rv_pkg::BLT;
                    3'b101: kind = rv_pkg::BGE;
                    3'b110: kind = rv_pkg::BLTU;
                    3'b111: kind = rv_pkg::BGEU;
                    default: kind = rv_pkg::UNKNOWN;
                endcase
            end
            rv_pkg::OPC_JAL:   kind = rv_pkg::JAL;
            rv_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) kind = rv_pkg::JALR;
            end
            rv_pkg::OPC_LUI:   kind = rv_pkg::LUI;
            rv_pkg::OPC_AUIPC: kind = rv_pkg::AUIPC;
            rv_pkg::OPC_MISC_MEM: begin
                if (funct3 == 3'b000) kind = rv_pkg::FENCE;
                else if (funct3 == 3'b001) kind = rv_pkg::FENCEI;
            end
            rv_pkg::OPC_SYSTEM: begin
                // anything else under SYSTEM is a CSR access and stays unknown
                if (inst_q[31:7] == 25'd0) kind = rv_pkg::ECALL;
                else if (inst_q[31:7] == {12'd1, 13'd0}) kind = rv_pkg::EBREAK;
            end
            default: kind = rv_pkg::UNKNOWN;
        endcase
    end

    always_comb begin
        dec_o.kind = kind;
        dec_o.rd   = inst_q[11:7];
        dec_o.rs1  = inst_q[19:15];
        dec_o.rs2  = inst_q[24:20];
        case (kind)
            rv_pkg::SLLI, rv_pkg::SRLI, rv_pkg::SRAI: dec_o.imm = imm_shamt;
            rv_pkg::ADDI, rv_pkg::SLTI, rv_pkg::SLTIU, rv_pkg::XORI,
            rv_pkg::ORI, rv_pkg::ANDI, rv_pkg::JALR:   dec_o.imm = imm_i_type;
            rv_pkg::BEQ, rv_pkg::BNE, rv_pkg::BLT, rv_pkg::BGE,
            rv_pkg::BLTU, rv_pkg::BGEU:                dec_o.imm = imm_b_type;
            rv_pkg::LUI, rv_pkg::AUIPC:                dec_o.imm = imm_u_type;
            rv_pkg::JAL:                               dec_o.imm = imm_j_type;
            default:                                   dec_o.imm = '0;
        endcase
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic             i_clk,
    input  logic             reset_i,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    output rv_pkg::xlen_t    rdata1_o,
    output rv_pkg::xlen_t    rdata2_o,
    input  logic             we_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  rv_pkg::xlen_t    wdata_i
);

    // x0 has no storage behind it
    rv_pkg::xlen_t regs [1:31];

    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // reads see the old value when the same register is written this cycle
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* design/execute.sv */
`timescale 1ns/1ps

module execute (
    input  rv_pkg::decoded_t     dec_i,
    input  rv_pkg::xlen_t        operand1_i,
    input  rv_pkg::xlen_t        operand2_i,
    input  rv_pkg::xlen_t        pc_i,
    output rv_pkg::exec_result_t res_o
);

    logic          use_imm;
    rv_pkg::xlen_t src_b;
    rv_pkg::xlen_t pc_plus4;
    rv_pkg::xlen_t pc_plus_imm;
    logic          taken;
    logic          writes;

    // the immediate forms share the ALU with their register forms
    assign use_imm = dec_i.kind inside {rv_pkg::ADDI, rv_pkg::XORI, rv_pkg::ORI,
                                        rv_pkg::ANDI, rv_pkg::SLLI, rv_pkg::SRLI,
                                        rv_pkg::SRAI, rv_pkg::SLTI, rv_pkg::SLTIU};
    assign src_b       = use_imm ? dec_i.imm : operand2_i;
    assign pc_plus4    = pc_i + 32'd4;
    assign pc_plus_imm = pc_i + dec_i.imm;

    // ----------------------------------------------------------
    // branch condition
    // ----------------------------------------------------------
    always_comb begin
        case (dec_i.kind)
            rv_pkg::BEQ:  taken = (operand1_i == operand2_i);
            rv_pkg::BNE:  taken = (operand1_i != operand2_i);
            rv_pkg::BLT:  taken = ($signed(operand1_i) <  $signed(operand2_i));
            rv_pkg::BGE:  taken = ($signed(operand1_i) >= $signed(operand2_i));
            rv_pkg::BLTU: taken = (operand1_i <  operand2_i);
            rv_pkg::BGEU: taken = (operand1_i >= operand2_i);
            default:      taken = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // result, target and flags
    // ----------------------------------------------------------
    always_comb begin
        res_o.result   = '0;
        res_o.target   = '0;
        res_o.redirect = 1'b0;
        writes         = 1'b1;
        case (dec_i.kind)
            rv_pkg::ADD, rv_pkg::ADDI: res_o.result = operand1_i + src_b;
            rv_pkg::SUB:               res_o.result = operand1_i - operand2_i;
            rv_pkg::XOR, rv_pkg::XORI: res_o.result = operand1_i ^ src_b;
            rv_pkg::OR,  rv_pkg::ORI:  res_o.result = operand1_i | src_b;
            rv_pkg::AND, rv_pkg::ANDI: res_o.result = operand1_i & src_b;
            rv_pkg::SLL, rv_pkg::SLLI: res_o.result = operand1_i << src_b[4:0];
            rv_pkg::SRL, rv_pkg::SRLI: res_o.result = operand1_i >> src_b[4:0];
            rv_pkg::SRA, rv_pkg::SRAI: res_o.result = $signed(operand1_i) >>> src_b[4:0];
            rv_pkg::SLT, rv_pkg::SLTI: begin
                res_o.result = {31'b0, $signed(operand1_i) < $signed(src_b)};
            end
            rv_pkg::SLTU, rv_pkg::SLTIU: begin
                res_o.result = {31'b0, operand1_i < src_b};
            end
            rv_pkg::BEQ, rv_pkg::BNE, rv_pkg::BLT, rv_pkg::BGE,
            rv_pkg::BLTU, rv_pkg::BGEU: begin
                res_o.result   = {31'b0, taken};
                res_o.target   = pc_plus_imm;
                res_o.redirect = taken;
                writes         = 1'b0;
            end
            rv_pkg::JAL: begin
                res_o.result   = pc_plus4;
                res_o.target   = pc_plus_imm;
                res_o.redirect = 1'b1;
            end
            rv_pkg::JALR: begin
                res_o.result   = pc_plus4;
                res_o.target   = (operand1_i + dec_i.imm) & ~32'd1;
                res_o.redirect = 1'b1;
            end
            rv_pkg::LUI:   res_o.result = dec_i.imm;
            rv_pkg::AUIPC: res_o.result = pc_plus_imm;
            // fences, system calls and unknown words retire without a write
            default: writes = 1'b0;
        endcase
        res_o.write_reg = writes && (dec_i.rd != '0);
    end

endmodule

/* design/pc_counter.sv */
`timescale 1ns/1ps

module pc_counter #(
    parameter rv_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
    input  logic          i_clk,
    input  logic          reset_i,
    input  logic          step_i,
    input  logic          redirect_i,
    input  rv_pkg::xlen_t target_i,
    output rv_pkg::xlen_t pc_o,
    output rv_pkg::xlen_t instret_o
);

    rv_pkg::xlen_t pc_q;
    rv_pkg::xlen_t instret_q;

    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (step_i) begin
            if (redirect_i) begin
                pc_q <= target_i;
            end else begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // one step per retired instruction
    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            instret_q <= '0;
        end else if (step_i) begin
            instret_q <= instret_q + 32'd1;
        end
    end

    assign pc_o      = pc_q;
    assign instret_o = instret_q;

endmodule

/* design/core_control.sv */
`timescale 1ns/1ps

module core_control (
    input  logic               i_clk,
    input  logic               reset_i,
    input  logic               run_i,
    input  rv_pkg::inst_kind_e kind_i,
    output logic               load_o,
    output logic               step_o,
    output logic               retire_o,
    output logic               halted_o
);

    rv_pkg::core_state_e state_q;
    rv_pkg::core_state_e state_d;

    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            state_q <= rv_pkg::FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_pkg::FETCH: begin
                if (run_i) state_d = rv_pkg::EXECUTE;
            end
            rv_pkg::EXECUTE: begin
                // a system call still retires before the core stops
                if (kind_i == rv_pkg::ECALL || kind_i == rv_pkg::EBREAK) begin
                    state_d = rv_pkg::HALT;
                end else begin
                    state_d = rv_pkg::FETCH;
                end
            end
            default: state_d = rv_pkg::HALT;
        endcase
    end

    assign load_o   = (state_q == rv_pkg::FETCH) && run_i;
    assign step_o   = (state_q == rv_pkg::EXECUTE);
    assign retire_o = (state_q == rv_pkg::EXECUTE);
    assign halted_o = (state_q == rv_pkg::HALT);

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
    input  logic            i_clk,
    input  logic            reset_i,
    input  logic            run_i,
    output rv_pkg::xlen_t   imem_addr_o,
    input  rv_pkg::xlen_t   imem_data_i,
    output logic            retire_o,
    output rv_pkg::retire_t retire_info_o,
    output logic            halted_o,
    output rv_pkg::xlen_t   instret_o
);

    logic                 load;
    logic                 step;
    rv_pkg::decoded_t     dec;
    rv_pkg::xlen_t        rdata1;
    rv_pkg::xlen_t        rdata2;
    rv_pkg::exec_result_t exec_res;
    rv_pkg::xlen_t        pc;

    core_control u_control (
        .i_clk   (i_clk),
        .reset_i (reset_i),
        .run_i   (run_i),
        .kind_i  (dec.kind),
        .load_o  (load),
        .step_o  (step),
        .retire_o(retire_o),
        .halted_o(halted_o)
    );

    pc_counter #(.RESET_PC(RESET_PC)) u_pc (
        .i_clk     (i_clk),
        .reset_i   (reset_i),
        .step_i    (step),
        .redirect_i(exec_res.redirect),
        .target_i  (exec_res.target),
        .pc_o      (pc),
        .instret_o (instret_o)
    );

    inst_decoder u_decoder (
        .i_clk  (i_clk),
        .reset_i(reset_i),
        .load_i (load),
        .inst_i (imem_data_i),
        .dec_o  (dec)
    );

    reg_file u_regs (
        .i_clk   (i_clk),
        .reset_i (reset_i),
        .rs1_i   (dec.rs1),
        .rs2_i   (dec.rs2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2),
        .we_i    (exec_res.write_reg && step),
        .rd_i    (dec.rd),
        .wdata_i (exec_res.result)
    );

    execute u_execute (
        .dec_i     (dec),
        .operand1_i(rdata1),
        .operand2_i(rdata2),
        .pc_i      (pc),
        .res_o     (exec_res)
    );

    // ----------------------------------------------------------
    // fetch address and retire record
    // ----------------------------------------------------------
    assign imem_addr_o = pc;

    assign retire_info_o.pc      = pc;
    assign retire_info_o.next_pc = exec_res.redirect ? exec_res.target : pc + 32'd4;
    assign retire_info_o.data    = exec_res.result;
    assign retire_info_o.rd      = dec.rd;
    assign retire_info_o.write   = exec_res.write_reg;

endmodule

/* testbench/tb_program.svh */
// add_row takes the test, instruction word, pc, next_pc, rd, write flag and data in that order
// add_gap marks a slot that a taken branch or jump steps over and that must never retire
localparam int NUM_ROWS = 49;

// ADDI x31, x0, -1 sits in every slot that is jumped over
localparam rv_pkg::xlen_t TRAP_WORD = 32'hFFF0_0F93;

task automatic load_program();
    // start-up and ALU work set up x1 = 5, x2 = -3 and x3 = 12
    add_row(1, 32'h00500093, 32'h00, 32'h04,  1, 1'b1, 32'h0000_0005);
    add_row(2, 32'hFFD00113, 32'h04, 32'h08,  2, 1'b1, 32'hFFFF_FFFD);
    add_row(2, 32'h00C00193, 32'h08, 32'h0C,  3, 1'b1, 32'h0000_000C);
    add_row(2, 32'h00208233, 32'h0C, 32'h10,  4, 1'b1, 32'h0000_0002);
    add_row(2, 32'h402082B3, 32'h10, 32'h14,  5, 1'b1, 32'h0000_0008);
    add_row(2, 32'h0030C333, 32'h14, 32'h18,  6, 1'b1, 32'h0000_0009);
    add_row(2, 32'h0030E3B3, 32'h18, 32'h1C,  7, 1'b1, 32'h0000_000D);
    add_row(2, 32'h0030F433, 32'h1C, 32'h20,  8, 1'b1, 32'h0000_0004);
    add_row(2, 32'h003094B3, 32'h20, 32'h24,  9, 1'b1, 32'h0000_5000);
    add_row(2, 32'h00115533, 32'h24, 32'h28, 10, 1'b1, 32'h07FF_FFFF);
    add_row(2, 32'h401155B3, 32'h28, 32'h2C, 11, 1'b1, 32'hFFFF_FFFF);
    add_row(2, 32'h00112633, 32'h2C, 32'h30, 12, 1'b1, 32'h0000_0001);
    add_row(2, 32'h001136B3, 32'h30, 32'h34, 13, 1'b1, 32'h0000_0000);
    add_row(2, 32'hFFF0C713, 32'h34, 32'h38, 14, 1'b1, 32'hFFFF_FFFA);
    add_row(2, 32'h0300E793, 32'h38, 32'h3C, 15, 1'b1, 32'h0000_0035);
    add_row(2, 32'h0F017813, 32'h3C, 32'h40, 16, 1'b1, 32'h0000_00F0);
    add_row(2, 32'h00409893, 32'h40, 32'h44, 17, 1'b1, 32'h0000_0050);
    add_row(2, 32'h01C15913, 32'h44, 32'h48, 18, 1'b1, 32'h0000_000F);
    add_row(2, 32'h40115993, 32'h48, 32'h4C, 19, 1'b1, 32'hFFFF_FFFE);
    add_row(2, 32'h00112A13, 32'h4C, 32'h50, 20, 1'b1, 32'h0000_0001);
    add_row(2, 32'hFFF0BA93, 32'h50, 32'h54, 21, 1'b1, 32'h0000_0001);
    // x0 is used first as destination and then as source
    add_row(3, 32'h00708013, 32'h54, 32'h58,  0, 1'b0, 32'h0000_000C);
    add_row(3, 32'h00300B33, 32'h58, 32'h5C, 22, 1'b1, 32'h0000_000C);
    // every branch has offset 8 so the rd field holds imm[4:1] and imm[11] which give 8
    add_row(4, 32'h00108463, 32'h5C, 32'h64,  8, 1'b0, 32'h0000_0001);
    add_gap(4);
    add_row(4, 32'h00308463, 32'h64, 32'h68,  8, 1'b0, 32'h0000_0000);
    add_row(4, 32'h00309463, 32'h68, 32'h70,  8, 1'b0, 32'h0000_0001);
    add_gap(4);
    add_row(4, 32'h00109463, 32'h70, 32'h74,  8, 1'b0, 32'h0000_0000);
    add_row(4, 32'h00114463, 32'h74, 32'h7C,  8, 1'b0, 32'h0000_0001);
    add_gap(4);
    add_row(4, 32'h0020C463, 32'h7C, 32'h80,  8, 1'b0, 32'h0000_0000);
    add_row(4, 32'h0020D463, 32'h80, 32'h88,  8, 1'b0, 32'h0000_0001);
    add_gap(4);
    add_row(4, 32'h00115463, 32'h88, 32'h8C,  8, 1'b0, 32'h0000_0000);
    add_row(4, 32'h0020E463, 32'h8C, 32'h94,  8, 1'b0, 32'h0000_0001);
    add_gap(4);
    add_row(4, 32'h00116463, 32'h94, 32'h98,  8, 1'b0, 32'h0000_0000);
    add_row(4, 32'h00117463, 32'h98, 32'hA0,  8, 1'b0, 32'h0000_0001);
    add_gap(4);
    add_row(4, 32'h0020F463, 32'hA0, 32'hA4,  8, 1'b0, 32'h0000_0000);
    // JAL skips one slot and JALR goes to x23 + 21 with bit 0 dropped
    add_row(5, 32'h00800BEF, 32'hA4, 32'hAC, 23, 1'b1, 32'h0000_00A8);
    add_gap(5);
    add_row(5, 32'h00001C17, 32'hAC, 32'hB0, 24, 1'b1, 32'h0000_10AC);
    add_row(5, 32'h12345CB7, 32'hB0, 32'hB4, 25, 1'b1, 32'h1234_5000);
    add_row(5, 32'h015B8D67, 32'hB4, 32'hBC, 26, 1'b1, 32'h0000_00B8);
    add_gap(5);
    // FENCE is followed by ECALL which stops the core
    add_row(6, 32'h0FF0000F, 32'hBC, 32'hC0,  0, 1'b0, 32'h0000_0000);
    add_row(6, 32'h00000073, 32'hC0, 32'hC4,  0, 1'b0, 32'h0000_0000);
endtask

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int CLK_PERIOD = 100;
    localparam rv_pkg::xlen_t NOP_WORD = 32'h0000_0013;

    typedef struct packed {
        logic [2:0]      test;
        logic            skip;
        rv_pkg::xlen_t   inst;
        rv_pkg::retire_t exp;
    } row_t;

    `include "tb_program.svh"

    logic            i_clk = 1'b0;
    logic            reset_i;
    logic            run_i;
    rv_pkg::xlen_t   imem_addr_o;
    rv_pkg::xlen_t   imem_data_i;
    logic            retire_o;
    rv_pkg::retire_t retire_info_o;
    logic            halted_o;
    rv_pkg::xlen_t   instret_o;

    row_t rows [NUM_ROWS];
    int   fill_index = 0;
    int   test_errors = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;

    rv_core dut0 (
        .i_clk        (i_clk),
        .reset_i      (reset_i),
        .run_i        (run_i),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .retire_o     (retire_o),
        .retire_info_o(retire_info_o),
        .halted_o     (halted_o),
        .instret_o    (instret_o)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // the instruction word follows the PC and is refreshed away from the rising edge
    always @(negedge i_clk) begin
        imem_data_i = fetch_word(imem_addr_o);
    end

    // ------------------------------------------------------------
    // table and check helpers
    // ------------------------------------------------------------
    task automatic add_row(input int test, input rv_pkg::xlen_t inst, input rv_pkg::xlen_t pc,
                           input rv_pkg::xlen_t next_pc, input rv_pkg::reg_idx_t rd,
                           input logic write, input rv_pkg::xlen_t data);
        rows[fill_index].test = test;
        rows[fill_index].skip = 1'b0;
        rows[fill_index].inst = inst;
        rows[fill_index].exp  = '{pc: pc, next_pc: next_pc, data: data, rd: rd, write: write};
        fill_index++;
    endtask

    task automatic add_gap(input int test);
        rows[fill_index].test = test;
        rows[fill_index].skip = 1'b1;
        rows[fill_index].inst = TRAP_WORD;
        rows[fill_index].exp  = '0;
        fill_index++;
    endtask

    function automatic rv_pkg::xlen_t fetch_word(input rv_pkg::xlen_t addr);
        int index;
        index = int'(addr >> 2);
        if (index < NUM_ROWS) begin
            return rows[index].inst;
        end
        return NOP_WORD;
    endfunction

    function automatic int retired_rows();
        int count;
        count = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!rows[r].skip) count++;
        end
        return count;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "reset and start-up";
            2: return "ALU work";
            3: return "x0 and register write";
            4: return "branches";
            5: return "jumps and upper immediates";
            default: return "halt and counting";
        endcase
    endfunction

    task automatic check_value(input string what, input rv_pkg::xlen_t got,
                               input rv_pkg::xlen_t expected);
        assert (got === expected) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got,
                     expected);
            test_errors++;
        end
    endtask

    task automatic wait_for_retire();
        do begin
            @(negedge i_clk);
        end while (retire_o !== 1'b1);
    endtask

    task automatic run_rows(input int t);
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].test == t && !rows[r].skip) begin
                wait_for_retire();
                check_value($sformatf("row %0d imem_addr_o", r), imem_addr_o,
                            rows[r].exp.pc);
                check_value($sformatf("row %0d pc", r), retire_info_o.pc, rows[r].exp.pc);
                check_value($sformatf("row %0d next_pc", r), retire_info_o.next_pc,
                            rows[r].exp.next_pc);
                check_value($sformatf("row %0d rd", r), retire_info_o.rd, rows[r].exp.rd);
                check_value($sformatf("row %0d write", r), retire_info_o.write,
                            rows[r].exp.write);
                check_value($sformatf("row %0d data", r), retire_info_o.data,
                            rows[r].exp.data);
            end
        end
    endtask

    task automatic report_test(input int t);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d (%s): passed", t, test_name(t));
        end else begin
            tests_failed++;
            $display("test %0d (%s): failed with %0d errors", t, test_name(t), test_errors);
        end
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        reset_i     = 1'b1;
        run_i       = 1'b0;
        imem_data_i = NOP_WORD;
        load_program();
        repeat (3) begin
            @(negedge i_clk);
            check_value("retire_o in reset", retire_o, 0);
            check_value("halted_o in reset", halted_o, 0);
        end
        reset_i = 1'b0;
        repeat (2) begin
            @(negedge i_clk);
            check_value("retire_o with run_i low", retire_o, 0);
            check_value("halted_o with run_i low", halted_o, 0);
        end
        run_i = 1'b1;
        run_rows(1);
        report_test(1);
        for (int t = 2; t <= 5; t++) begin
            run_rows(t);
            report_test(t);
        end
        run_rows(6);
        @(negedge i_clk);
        check_value("halted_o after ECALL", halted_o, 1);
        repeat (6) begin
            @(negedge i_clk);
            check_value("retire_o while halted", retire_o, 0);
        end
        check_value("instret_o", instret_o, retired_rows());
        report_test(6);
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // the limit allows two cycles per row plus room for reset and the halt check
    initial begin
        #((NUM_ROWS * 2 + 20) * CLK_PERIOD);
        $display("timeout: retire_o did not arrive within %0d cycles", NUM_ROWS * 2 + 20);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* sim.f */
+incdir+testbench
design/rv_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/execute.sv
design/pc_counter.sv
design/core_control.sv
design/rv_core.sv
testbench/tb_rv_core.sv
